/* run.sh */
#!/usr/bin/env bash
# build and run the execute unit testbench with verilator, pass is judged from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_ex_unit -f vlog.f -o tb_ex_unit > build.log 2>&1 \
  && ./obj_dir/tb_ex_unit > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat build.log; exit 1; }

cat sim.log
grep -qx "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* sim/ex_tb_pkg.sv */
// run lengths, reference model and random instruction builders for the testbench
package ex_tb_pkg;
  import ex_pkg::*;

  localparam int N_ALU           = 200;
  localparam int N_BRANCH        = 7 * 3 * 4;  // kinds x relations x repeats
  localparam int N_LOAD          = 7 * 10;
  localparam int N_CSR           = 40;
  localparam int N_TRAP          = 20;
  localparam int N_STALL         = 150;
  localparam int N_TOTAL         = N_ALU + N_BRANCH + N_LOAD + N_CSR + N_TRAP + N_STALL;
  localparam int WATCHDOG_CYCLES = N_TOTAL * 20 + 500;

  function automatic logic [XLEN-1:0] rand64();
    return {$urandom, $urandom};
  endfunction

  ////////////////////
  // reference model
  ////////////////////
  function automatic logic [XLEN-1:0] alu_model(alu_op_e f, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b, logic w);
    int                 sh;
    logic [XLEN-1:0]    r;
    logic signed [31:0] lo;
    sh = w ? int'(b[4:0]) : int'(b[5:0]);
    lo = a[31:0];
    case (f)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a - b;
      ALU_AND:  r = a & b;
      ALU_OR:   r = a | b;
      ALU_XOR:  r = a ^ b;
      ALU_SLL:  r = a << sh;
      ALU_SRL: begin
        if (w) begin
          r = {32'b0, a[31:0] >> sh};
        end else begin
          r = a >> sh;
        end
      end
      ALU_SRA: begin
        if (w) begin
          r = {32'b0, lo >>> sh};
        end else begin
          r = $signed(a) >>> sh;
        end
      end
      ALU_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      ALU_SLTU: r = (a < b) ? 64'd1 : 64'd0;
      default:  r = '0;
    endcase
    if (w) begin
      r = {{32{r[31]}}, r[31:0]};  // word result is sign-extended
    end
    return r;
  endfunction

  function automatic logic [XLEN-1:0] extend_load(mem_op_e m, logic [XLEN-1:0] d);
    logic [XLEN-1:0] mask;
    logic            is_signed;
    logic            sign_bit;
    case (m)
      MEM_LB, MEM_LBU: mask = 64'h0000_0000_0000_00ff;
      MEM_LH, MEM_LHU: mask = 64'h0000_0000_0000_ffff;
      MEM_LW, MEM_LWU: mask = 64'h0000_0000_ffff_ffff;
      default:         mask = '1;
    endcase
    is_signed = (m == MEM_LB) || (m == MEM_LH) || (m == MEM_LW);
    sign_bit  = |(d & mask & ~(mask >> 1));  // top bit of the loaded field
    return (is_signed && sign_bit) ? ((d & mask) | ~mask) : (d & mask);
  endfunction

  function automatic ex_res_t expect_result(ex_op_t op);
    ex_res_t         res;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] alu;
    logic            taken;
    a = op.alu_a_src ? op.pc : op.rs1;
    case (op.alu_b_src)
      2'b00:   b = op.rs2;
      2'b01:   b = op.imm;
      2'b10:   b = 64'd4;
      default: b = '0;
    endcase
    alu = alu_model(op.alu_op, a, b, op.word_cut);
    case (op.branch)
      BR_JAL, BR_JALR: taken = 1'b1;
      BR_BEQ:  taken = (op.rs1 == op.rs2);
      BR_BNE:  taken = (op.rs1 != op.rs2);
      BR_BLT:  taken = ($signed(op.rs1) < $signed(op.rs2));
      BR_BGE:  taken = ($signed(op.rs1) >= $signed(op.rs2));
      default: taken = 1'b0;
    endcase
    res.next_pc   = ((op.branch == BR_JALR) ? op.rs1 : op.pc) + (taken ? op.imm : 64'd4);
    res.gpr_wdata = op.mem_to_reg ? extend_load(op.mem_op, op.rdata)
                                  : (op.sel_csr ? op.rs2 : alu);
    res.csr_wdata = op.csr_write ? a : '0;
    res.halt      = op.is_ebreak;
    res.illegal   = op.is_invalid;
    return res;
  endfunction

  ////////////////////
  // instruction builders
  ////////////////////
  function automatic branch_e branch_kind(int i);
    case (i)
      0:       return BR_NONE;
      1:       return BR_JAL;
      2:       return BR_JALR;
      3:       return BR_BEQ;
      4:       return BR_BNE;
      5:       return BR_BLT;
      default: return BR_BGE;
    endcase
  endfunction

  function automatic ex_op_t build_alu_op();
    ex_op_t op;
    op           = '0;
    op.rs1       = rand64();
    op.rs2       = rand64();
    op.imm       = rand64();
    op.pc        = rand64();
    op.rdata     = rand64();
    op.alu_a_src = 1'($urandom_range(1));
    op.alu_b_src = 2'($urandom_range(2));
    op.alu_op    = alu_op_e'(4'($urandom_range(9)));
    op.word_cut  = 1'($urandom_range(1));
    op.mem_op    = MEM_LD;
    return op;
  endfunction

  // rel 0 equal, 1 rs1 below rs2, 2 rs1 above rs2 (signed)
  function automatic ex_op_t build_branch_op(branch_e kind, int rel);
    ex_op_t          op;
    logic [XLEN-1:0] x;
    logic [XLEN-1:0] y;
    logic [XLEN-1:0] lo;
    logic [XLEN-1:0] hi;
    op = build_alu_op();
    x  = rand64();
    y  = rand64();
    if (x == y) begin
      y = ~x;
    end
    lo = ($signed(x) < $signed(y)) ? x : y;
    hi = ($signed(x) < $signed(y)) ? y : x;
    case (rel)
      0: begin
        op.rs1 = x;
        op.rs2 = x;
      end
      1: begin
        op.rs1 = lo;
        op.rs2 = hi;
      end
      default: begin
        op.rs1 = hi;
        op.rs2 = lo;
      end
    endcase
    op.branch    = kind;
    op.alu_a_src = 1'b1;   // link value pc + 4
    op.alu_b_src = SRC_B_FOUR;
    op.alu_op    = ALU_ADD;
    op.word_cut  = 1'b0;
    return op;
  endfunction

  function automatic ex_op_t build_load_op(mem_op_e m);
    ex_op_t op;
    op            = build_alu_op();
    op.mem_op     = m;
    op.mem_to_reg = 1'b1;
    return op;
  endfunction

  function automatic ex_op_t build_csr_op();
    ex_op_t op;
    op           = build_alu_op();
    op.sel_csr   = 1'($urandom_range(1));
    op.csr_write = 1'($urandom_range(1));
    return op;
  endfunction

  function automatic ex_op_t build_trap_op();
    ex_op_t     op;
    logic [1:0] traps;
    op            = build_alu_op();
    traps         = 2'($urandom_range(3));
    op.is_ebreak  = traps[0];
    op.is_invalid = traps[1];
    return op;
  endfunction

  function automatic ex_op_t build_mixed_op();
    ex_op_t op;
    case ($urandom_range(4))
      0:       op = build_alu_op();
      1:       op = build_branch_op(branch_kind(int'($urandom_range(6))),
                                    int'($urandom_range(2)));
      2:       op = build_load_op(mem_op_e'(3'($urandom_range(6))));
      3:       op = build_csr_op();
      default: op = build_trap_op();
    endcase
    return op;
  endfunction

endpackage

/* sim/tb_ex_unit.sv */
// execute unit testbench with clock, reset, stimulus, scoreboard, assertions and watchdog
module tb_ex_unit;
  timeunit 1ns;
  timeprecision 1ps;
  import ex_pkg::*;
  import ex_tb_pkg::*;

  logic    clk;
  logic    rst;
  logic    in_valid;
  ex_op_t  in_op;
  logic    in_ready;
  logic    out_valid;
  ex_res_t out_res;
  logic    out_ready;

  ex_res_t exp_q[$];
  string   name_q[$];
  ex_res_t exp_res;
  string   exp_name;
  logic    heavy_stall;
  int      stretch;
  int      outstanding;
  int      sent          = 0;
  int      delivered     = 0;
  int      mismatch_errs = 0;
  int      assert_errs   = 0;
  int      other_errs    = 0;

  ex_unit UUT (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_op_valid  (in_valid),
    .i_op        (in_op),
    .i_res_ready (out_ready),
    .o_op_ready  (in_ready),
    .o_res_valid (out_valid),
    .o_res       (out_res)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  ////////////////////
  // stimulus
  ////////////////////
  task automatic send_op(input ex_op_t instr, input string name);
    logic took;
    in_op    = instr;
    in_valid = 1'b1;
    took     = 1'b0;
    while (!took) begin
      took = in_ready;   // credit count is steady through the cycle
      @(posedge clk);
      #1;
    end
    exp_q.push_back(expect_result(instr));
    name_q.push_back(name);
    sent++;
    in_valid = 1'b0;
  endtask

  initial begin
    void'($urandom(1));
    rst         = 1'b1;
    in_valid    = 1'b0;
    in_op       = '0;
    heavy_stall = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < N_ALU; i++) begin
      send_op(build_alu_op(), "alu");
    end
    for (int k = 0; k < 7; k++) begin
      for (int rel = 0; rel < 3; rel++) begin
        repeat (4) send_op(build_branch_op(branch_kind(k), rel), "branch");
      end
    end
    for (int m = 0; m < 7; m++) begin
      repeat (10) send_op(build_load_op(mem_op_e'(3'(m))), "load");
    end
    repeat (N_CSR) send_op(build_csr_op(), "csr");
    repeat (N_TRAP) send_op(build_trap_op(), "trap");
    heavy_stall = 1'b1;   // long stalls on the result side from here on
    repeat (N_STALL) send_op(build_mixed_op(), "stall");
    wait (delivered == sent);
    repeat (5) @(posedge clk);
    $display("errors: mismatch %0d, assertion %0d, other %0d",
             mismatch_errs, assert_errs, other_errs);
    if (mismatch_errs + assert_errs + other_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // short ready gaps normally and long low stretches under stall
  initial begin
    out_ready = 1'b0;
    stretch   = 0;
    forever begin
      @(posedge clk);
      #1;
      if (stretch == 0) begin
        if (heavy_stall) begin
          out_ready = ~out_ready;
          stretch   = out_ready ? $urandom_range(3, 1) : $urandom_range(30, 8);
        end else begin
          out_ready = ($urandom_range(9) != 0);
          stretch   = 1;
        end
      end
      stretch = stretch - 1;
    end
  end

  ////////////////////
  // scoreboard
  ////////////////////
  always @(negedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("a result came out with no instruction outstanding");
      end else begin
        exp_res  = exp_q.pop_front();
        exp_name = name_q.pop_front();
        result_check: assert (out_res == exp_res)
          else begin
            mismatch_errs++;
            $display("mismatch %s expected %h actual %h", exp_name, exp_res, out_res);
          end
        delivered++;
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(in_valid && in_ready) - int'(out_valid && out_ready);
    end
  end

  ////////////////////
  // assertions
  ////////////////////
  hold_check: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_res))
    else begin
      assert_errs++;
      $display("result changed or was dropped while the output was stalled");
    end

  credit_check: assert property (@(posedge clk) disable iff (rst)
    outstanding > QUEUE_DEPTH |-> !in_ready)
    else begin
      assert_errs++;
      $display("input still ready with %0d instructions in flight", outstanding);
    end

  flight_check: assert property (@(posedge clk) disable iff (rst)
    outstanding <= QUEUE_DEPTH + 2)
    else begin
      assert_errs++;
      $display("too many instructions in flight: %0d", outstanding);
    end

  reset_check: assert property (@(posedge clk) $fell(rst) |-> !out_valid && in_ready)
    else begin
      assert_errs++;
      $display("wrong output state right after reset");
    end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: only %0d of %0d results arrived within %0d cycles",
             delivered, sent, WATCHDOG_CYCLES);
    $display("errors: mismatch %0d, assertion %0d, other %0d",
             mismatch_errs, assert_errs, other_errs + 1);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* source/ex_commit.sv */
// commit block with next pc, load extension, write-back and csr select, output register
module ex_commit (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_valid,
  input  ex_pkg::ex_mid_t  i_head,
  input  logic             i_res_ready,
  output logic             o_pop,
  output logic             o_res_valid,
  output ex_pkg::ex_res_t  o_res
);
  import ex_pkg::*;

  logic            add_imm;    // target offset is imm or 4
  logic            base_rs1;   // target base is rs1 or pc
  logic [XLEN-1:0] load_data;
  ex_res_t         res_next;

  // take the head when the output slot is free or leaving this cycle
  assign o_pop = i_valid & (~o_res_valid | i_res_ready);

  ////////////////////
  // next pc
  ////////////////////
  always_comb begin
    add_imm  = 1'b0;
    base_rs1 = 1'b0;
    case (i_head.branch)
      BR_JAL:  add_imm = 1'b1;
      BR_JALR: begin
        add_imm  = 1'b1;
        base_rs1 = 1'b1;
      end
      BR_BEQ:  add_imm = i_head.zero;
      BR_BNE:  add_imm = ~i_head.zero;
      BR_BLT:  add_imm = i_head.less;
      BR_BGE:  add_imm = ~i_head.less;
      default: add_imm = 1'b0;
    endcase
  end

  ////////////////////
  // load extension
  ////////////////////
  always_comb begin
    case (i_head.mem_op)
      MEM_LB:  load_data = {{56{i_head.rdata[7]}}, i_head.rdata[7:0]};
      MEM_LBU: load_data = {56'b0, i_head.rdata[7:0]};
      MEM_LH:  load_data = {{48{i_head.rdata[15]}}, i_head.rdata[15:0]};
      MEM_LHU: load_data = {48'b0, i_head.rdata[15:0]};
      MEM_LW:  load_data = {{32{i_head.rdata[31]}}, i_head.rdata[31:0]};
      MEM_LWU: load_data = {32'b0, i_head.rdata[31:0]};
      MEM_LD:  load_data = i_head.rdata;
      default: load_data = '0;
    endcase
  end

  always_comb begin
    res_next.next_pc   = (base_rs1 ? i_head.rs1 : i_head.pc)
                       + (add_imm ? i_head.imm : XLEN'(4));
    res_next.gpr_wdata = i_head.mem_to_reg ? load_data
                       : (i_head.sel_csr ? i_head.rs2 : i_head.alu_result);
    res_next.csr_wdata = i_head.csr_write ? i_head.alu_a : '0;
    res_next.halt      = i_head.is_ebreak;
    res_next.illegal   = i_head.is_invalid;
  end

  ////////////////////
  // output register
  ////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_res_valid <= 1'b0;
    end else if (o_pop) begin
      o_res_valid <= 1'b1;
    end else if (i_res_ready) begin
      o_res_valid <= 1'b0;
    end
  end

  // holds while stalled
  always_ff @(posedge i_clk) begin
    if (o_pop) begin
      o_res <= res_next;
    end
  end

endmodule

/* source/ex_issue.sv */
// issue block with operand select, alu, branch flags, push register and credit counter
module ex_issue (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_op_valid,
  input  ex_pkg::ex_op_t   i_op,
  input  logic             i_credit,
  output logic             o_op_ready,
  output logic             o_push,
  output ex_pkg::ex_mid_t  o_mid
);
  import ex_pkg::*;

  logic [CREDIT_W-1:0] credit_cnt;
  logic                accept;

  logic [XLEN-1:0]     alu_a;
  logic [XLEN-1:0]     alu_b;
  logic [5:0]          shamt;
  logic [31:0]         srl_word;
  logic [31:0]         sra_word;
  logic [XLEN-1:0]     sra_full;
  logic [XLEN-1:0]     alu_raw;
  logic [XLEN-1:0]     alu_result;

  assign o_op_ready = (credit_cnt != '0);
  assign accept     = i_op_valid & o_op_ready;

  ////////////////////
  // operands and alu
  ////////////////////
  assign alu_a = i_op.alu_a_src ? i_op.pc : i_op.rs1;

  always_comb begin
    case (i_op.alu_b_src)
      SRC_B_RS2:  alu_b = i_op.rs2;
      SRC_B_IMM:  alu_b = i_op.imm;
      SRC_B_FOUR: alu_b = XLEN'(4);
      default:    alu_b = '0;
    endcase
  end

  // word ops shift by 5 bits and see only the low word
  assign shamt    = i_op.word_cut ? {1'b0, alu_b[4:0]} : alu_b[5:0];
  assign srl_word = alu_a[31:0] >> shamt;
  assign sra_word = $signed(alu_a[31:0]) >>> shamt;
  assign sra_full = $signed(alu_a) >>> shamt;

  always_comb begin
    case (i_op.alu_op)
      ALU_ADD:  alu_raw = alu_a + alu_b;
      ALU_SUB:  alu_raw = alu_a - alu_b;
      ALU_AND:  alu_raw = alu_a & alu_b;
      ALU_OR:   alu_raw = alu_a | alu_b;
      ALU_XOR:  alu_raw = alu_a ^ alu_b;
      ALU_SLL:  alu_raw = alu_a << shamt;
      ALU_SRL:  alu_raw = i_op.word_cut ? {32'b0, srl_word} : alu_a >> shamt;
      ALU_SRA:  alu_raw = i_op.word_cut ? {32'b0, sra_word} : sra_full;
      ALU_SLT:  alu_raw = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU: alu_raw = {{(XLEN-1){1'b0}}, alu_a < alu_b};
      default:  alu_raw = '0;
    endcase
  end

  assign alu_result = i_op.word_cut ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  ////////////////////
  // push register
  ////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_push <= 1'b0;
    end else begin
      o_push <= accept;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_mid.alu_result <= alu_result;
      o_mid.alu_a      <= alu_a;
      o_mid.rs1        <= i_op.rs1;
      o_mid.rs2        <= i_op.rs2;
      o_mid.imm        <= i_op.imm;
      o_mid.pc         <= i_op.pc;
      o_mid.rdata      <= i_op.rdata;
      o_mid.zero       <= (i_op.rs1 == i_op.rs2);
      o_mid.less       <= ($signed(i_op.rs1) < $signed(i_op.rs2));
      o_mid.branch     <= i_op.branch;
      o_mid.mem_op     <= i_op.mem_op;
      o_mid.mem_to_reg <= i_op.mem_to_reg;
      o_mid.sel_csr    <= i_op.sel_csr;
      o_mid.csr_write  <= i_op.csr_write;
      o_mid.is_ebreak  <= i_op.is_ebreak;
      o_mid.is_invalid <= i_op.is_invalid;
    end
  end

  // a credit is spent on accept, so the push register always has a slot waiting
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      credit_cnt <= CREDIT_W'(QUEUE_DEPTH);
    end else begin
      case ({accept, i_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;   // none or spend and return together
      endcase
    end
  end

endmodule

/* source/ex_pkg.sv */
// widths, alu/branch/load encodings, queue depth and payload structs of the execute stage
package ex_pkg;

  ////////////////////
  // widths and depths
  ////////////////////
  localparam int XLEN        = 64;
  localparam int QUEUE_DEPTH = 4;
  localparam int CREDIT_W    = 3;   // holds 0 .. QUEUE_DEPTH
  localparam int PTR_W       = 2;   // queue index wraps on its own

  // operand b sources
  localparam logic [1:0] SRC_B_RS2   = 2'b00;
  localparam logic [1:0] SRC_B_IMM   = 2'b01;
  localparam logic [1:0] SRC_B_FOUR  = 2'b10;

  ////////////////////
  // encodings
  ////////////////////
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_BEQ  = 3'b100,
    BR_BNE  = 3'b101,
    BR_BLT  = 3'b110,
    BR_BGE  = 3'b111
  } branch_e;

  typedef enum logic [2:0] {
    MEM_LB  = 3'b000,
    MEM_LBU = 3'b001,
    MEM_LH  = 3'b010,
    MEM_LHU = 3'b011,
    MEM_LW  = 3'b100,
    MEM_LWU = 3'b101,
    MEM_LD  = 3'b110
  } mem_op_e;

  ////////////////////
  // payloads
  ////////////////////
  // decoded instruction with operands already read
  typedef struct packed {
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rdata;     // load data comes with the op
    logic            alu_a_src; // 0 rs1, 1 pc
    logic [1:0]      alu_b_src;
    alu_op_e         alu_op;
    logic            word_cut;
    branch_e         branch;
    mem_op_e         mem_op;
    logic            mem_to_reg;
    logic            sel_csr;
    logic            csr_write;
    logic            is_ebreak;
    logic            is_invalid;
  } ex_op_t;

  // issued op as stored in the queue
  typedef struct packed {
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rdata;
    logic            zero;
    logic            less;
    branch_e         branch;
    mem_op_e         mem_op;
    logic            mem_to_reg;
    logic            sel_csr;
    logic            csr_write;
    logic            is_ebreak;
    logic            is_invalid;
  } ex_mid_t;

  typedef struct packed {
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] gpr_wdata;
    logic [XLEN-1:0] csr_wdata;
    logic            halt;
    logic            illegal;
  } ex_res_t;

endpackage

/* source/ex_queue.sv */
// issue queue fifo of issued ops with one credit pulse per pop
module ex_queue (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_push,
  input  ex_pkg::ex_mid_t  i_mid,
  input  logic             i_pop,
  output logic             o_valid,
  output ex_pkg::ex_mid_t  o_head,
  output logic             o_credit
);
  import ex_pkg::*;

  ex_mid_t             mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CREDIT_W-1:0] count;
  logic                pop_en;

  assign o_valid = (count != '0);
  assign o_head  = mem[rd_ptr];
  assign pop_en  = i_pop & o_valid;

  // entry storage
  always_ff @(posedge i_clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_mid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      o_credit <= 1'b0;
    end else begin
      o_credit <= pop_en;   // credit goes back a cycle after the pop
      if (i_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({i_push, pop_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* source/ex_unit.sv */
// execute unit top level with the issue, queue and commit blocks
module ex_unit (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_op_valid,
  input  ex_pkg::ex_op_t   i_op,
  input  logic             i_res_ready,
  output logic             o_op_ready,
  output logic             o_res_valid,
  output ex_pkg::ex_res_t  o_res
);
  import ex_pkg::*;

  logic    push;
  ex_mid_t mid;
  logic    credit;
  logic    head_valid;
  ex_mid_t head;
  logic    pop;

  ex_issue u_issue (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_op_valid (i_op_valid),
    .i_op       (i_op),
    .i_credit   (credit),
    .o_op_ready (o_op_ready),
    .o_push     (push),
    .o_mid      (mid)
  );

  ex_queue u_queue (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_push   (push),
    .i_mid    (mid),
    .i_pop    (pop),
    .o_valid  (head_valid),
    .o_head   (head),
    .o_credit (credit)
  );

  ex_commit u_commit (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (head_valid),
    .i_head      (head),
    .i_res_ready (i_res_ready),
    .o_pop       (pop),
    .o_res_valid (o_res_valid),
    .o_res       (o_res)
  );

endmodule

/* vlog.f */
source/ex_pkg.sv
source/ex_issue.sv
source/ex_queue.sv
source/ex_commit.sv
source/ex_unit.sv
sim/ex_tb_pkg.sv
sim/tb_ex_unit.sv
